/* hw/dtlb_ctrl.sv */
module dtlb_ctrl import dtlb_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  // Flush command
  input  flush_e            flush_type_i,
  input  logic [ASID_W-1:0] flush_asid_i,
  input  vpn_u              flush_vpn_i,
  // LSQ request
  input  logic              req_valid_i,
  input  vpn_u              req_vpn_i,
  input  logic              req_store_i,
  output logic              req_ready_o,
  // Context from the CSRs
  input  logic [ASID_W-1:0] asid_i,
  input  priv_e             priv_i,
  input  logic              sum_i,
  input  logic              mxr_i,
  // Merged hit from the entries
  input  logic              lookup_hit_i,
  // Miss request to the L2 TLB
  output logic              l2_req_valid_o,
  output vpn_u              l2_req_vpn_o,
  input  logic              l2_req_ready_i,
  // L2 TLB answer
  input  logic              l2_ans_valid_i,
  input  vpn_u              l2_ans_vpn_i,
  input  logic [PPN_W-1:0]  l2_ans_ppn_i,
  input  page_e             l2_ans_page_i,
  input  logic              l2_ans_glob_i,
  input  logic              l2_ans_user_i,
  input  logic              l2_ans_read_i,
  input  logic              l2_ans_write_i,
  input  logic              l2_ans_dirty_i,
  input  logic              l2_ans_fault_i,
  // Wake-up of the waiting LSQ slot
  output logic              wup_valid_o,
  output vpn_u              wup_vpn_o,
  output logic [PPN_W-1:0]  wup_ppn_o,
  output logic              wup_fault_o,
  dtlb_lookup_if.drv        lookup,
  dtlb_maint_if.drv         maint
);

  // Single miss register
  logic miss_req_q;
  logic miss_wait_q;
  vpn_u miss_vpn_q;

  logic flush_act;
  logic miss_capture;
  logic ans_take;

  // Flush wins over everything else
  assign flush_act = (flush_type_i != FLUSH_NONE);

  // No new lookup while flushing, answering, or holding a miss
  assign req_ready_o = !flush_act && !l2_ans_valid_i && !miss_req_q && !miss_wait_q;

  // Lookup broadcast, valid only in an accept cycle
  assign lookup.lookup_valid = req_valid_i && req_ready_o;
  assign lookup.vpn          = req_vpn_i;
  assign lookup.is_store     = req_store_i;
  assign lookup.asid         = asid_i;
  assign lookup.priv         = priv_i;
  assign lookup.sum          = sum_i;
  assign lookup.mxr          = mxr_i;

  assign miss_capture = lookup.lookup_valid && !lookup_hit_i;

  // Answer counts only for the waiting miss, compared at the answer page size
  assign ans_take = !flush_act && l2_ans_valid_i && miss_wait_q &&
                    vpn_match(miss_vpn_q, l2_ans_vpn_i, l2_ans_page_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      miss_req_q  <= 1'b0;
      miss_wait_q <= 1'b0;
    end else begin
      if (miss_capture) begin
        miss_req_q <= 1'b1;
      end else if (miss_req_q && l2_req_ready_i) begin
        // Handed to the L2, now waiting for the answer
        miss_req_q  <= 1'b0;
        miss_wait_q <= 1'b1;
      end else if (ans_take) begin
        miss_wait_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (miss_capture) begin
      miss_vpn_q <= req_vpn_i;
    end
  end

  assign l2_req_valid_o = miss_req_q;
  assign l2_req_vpn_o   = miss_vpn_q;

  // Wake-up forwards the answer as it is, fault included
  assign wup_valid_o = ans_take;
  assign wup_vpn_o   = l2_ans_vpn_i;
  assign wup_ppn_o   = l2_ans_ppn_i;
  assign wup_fault_o = l2_ans_fault_i;

  // Faulting translations are not cached
  assign maint.fill_en    = ans_take && !l2_ans_fault_i;
  assign maint.fill_vpn   = l2_ans_vpn_i;
  assign maint.fill_ppn   = l2_ans_ppn_i;
  assign maint.fill_page  = l2_ans_page_i;
  assign maint.fill_asid  = asid_i;
  assign maint.fill_glob  = l2_ans_glob_i;
  assign maint.fill_user  = l2_ans_user_i;
  assign maint.fill_read  = l2_ans_read_i;
  assign maint.fill_write = l2_ans_write_i;
  assign maint.fill_dirty = l2_ans_dirty_i;

  assign maint.flush_type = flush_type_i;
  assign maint.flush_asid = flush_asid_i;
  assign maint.flush_vpn  = flush_vpn_i;

  // L2 request holds under back-pressure
  l2_req_stable_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    l2_req_valid_o && !l2_req_ready_i |=> l2_req_valid_o && $stable(l2_req_vpn_o)
  );

endmodule

/* hw/dtlb_entry.sv */
module dtlb_entry import dtlb_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_ni,
  dtlb_lookup_if.rcv       lookup,
  dtlb_maint_if.rcv        maint,
  // One-hot slice of the PLRU replace vector
  input  logic             fill_sel_i,
  output logic             valid_o,
  output logic             hit_o,
  output logic             fault_o,
  output logic [PPN_W-1:0] ppn_o
);

  logic              valid_q;
  vpn_u              vpn_q;
  logic [PPN_W-1:0]  ppn_q;
  page_e             page_q;
  logic [ASID_W-1:0] asid_q;
  logic              glob_q;
  logic              user_q;
  logic              read_q;
  logic              write_q;
  logic              dirty_q;

  logic asid_ok;
  logic flush_hit;
  logic write_en;

  assign write_en = maint.fill_en && fill_sel_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (flush_hit) begin
      valid_q <= 1'b0;
    end else if (write_en) begin
      valid_q <= 1'b1;
    end
  end

  // Translation payload
  always_ff @(posedge clk_i) begin
    if (write_en) begin
      vpn_q   <= maint.fill_vpn;
      ppn_q   <= maint.fill_ppn;
      page_q  <= maint.fill_page;
      asid_q  <= maint.fill_asid;
      glob_q  <= maint.fill_glob;
      user_q  <= maint.fill_user;
      read_q  <= maint.fill_read;
      write_q <= maint.fill_write;
      dirty_q <= maint.fill_dirty;
    end
  end

  // Global pages ignore the ASID
  assign asid_ok = glob_q || (asid_q == lookup.asid);

  assign hit_o = lookup.lookup_valid && valid_q && asid_ok &&
                 vpn_match(vpn_q, lookup.vpn, page_q);

  always_comb begin
    fault_o = 1'b0;
    if (hit_o) begin
      // No read permission unless MXR makes it readable
      if (!read_q && !lookup.mxr) begin
        fault_o = 1'b1;
      end
      // Store needs a writable and already dirty page
      if (lookup.is_store && (!write_q || !dirty_q)) begin
        fault_o = 1'b1;
      end
      // User page from S mode only with SUM set
      if (user_q && (lookup.priv == PRIV_S) && !lookup.sum) begin
        fault_o = 1'b1;
      end
      // Supervisor page never reachable from U mode
      if (!user_q && (lookup.priv == PRIV_U)) begin
        fault_o = 1'b1;
      end
    end
  end

  always_comb begin
    case (maint.flush_type)
      FLUSH_ALL:  flush_hit = 1'b1;
      FLUSH_ASID: flush_hit = (asid_q == maint.flush_asid) && !glob_q;
      // Page compare at this entry's own size
      FLUSH_PAGE: flush_hit = vpn_match(vpn_q, maint.flush_vpn, page_q);
      default:    flush_hit = 1'b0;
    endcase
  end

  assign valid_o = valid_q;
  assign ppn_o   = ppn_q;

  // Refill and flush are never issued in the same cycle
  fill_flush_excl_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(maint.fill_en && (maint.flush_type != FLUSH_NONE))
  );

endmodule

/* hw/dtlb_hit_select.sv */
module dtlb_hit_select import dtlb_pkg::*; (
  input  logic [DTLB_ENTRIES-1:0]            hit_vec_i,
  input  logic [DTLB_ENTRIES-1:0]            fault_vec_i,
  input  logic [DTLB_ENTRIES-1:0][PPN_W-1:0] ppn_arr_i,
  input  logic [LSQ_TAG_W-1:0]               req_tag_i,
  input  logic                               req_store_i,
  output logic                               lookup_hit_o,
  output logic [DTLB_ENTRIES-1:0]            touch_vec_o,
  output logic                               ans_valid_o,
  output logic [PPN_W-1:0]                   ans_ppn_o,
  output logic                               ans_fault_o,
  output logic [LSQ_TAG_W-1:0]               ans_tag_o,
  output logic                               ans_store_o
);

  assign lookup_hit_o = |hit_vec_i;

  // AND-OR mux, the hit vector is at most one-hot
  always_comb begin
    ans_ppn_o   = '0;
    ans_fault_o = 1'b0;
    for (int i = 0; i < DTLB_ENTRIES; i++) begin
      if (hit_vec_i[i]) begin
        ans_ppn_o   = ans_ppn_o | ppn_arr_i[i];
        ans_fault_o = ans_fault_o | fault_vec_i[i];
      end
    end
  end

  // Faulting hits do not count as use for replacement
  assign touch_vec_o = hit_vec_i & ~fault_vec_i;

  // Answer only on hit, misses go through the L2
  assign ans_valid_o = lookup_hit_o;
  assign ans_tag_o   = req_tag_i;
  assign ans_store_o = req_store_i;

  hit_onehot_a: assert final ($onehot0(hit_vec_i));

endmodule

/* hw/dtlb_lookup_if.sv */
interface dtlb_lookup_if import dtlb_pkg::*; ();

  // Accepted request, high for one cycle per lookup
  logic          lookup_valid;
  vpn_u          vpn;
  logic          is_store;
  // Translation context sampled with the lookup
  logic [ASID_W-1:0] asid;
  priv_e         priv;
  logic          sum;
  logic          mxr;

  // Controller side
  modport drv (
    output lookup_valid, vpn, is_store, asid, priv, sum, mxr
  );

  // Entry side
  modport rcv (
    input lookup_valid, vpn, is_store, asid, priv, sum, mxr
  );

endinterface

/* hw/dtlb_maint_if.sv */
interface dtlb_maint_if import dtlb_pkg::*; ();

  // Refill of one entry, the target comes from the PLRU
  logic              fill_en;
  vpn_u              fill_vpn;
  logic [PPN_W-1:0]  fill_ppn;
  page_e             fill_page;
  logic [ASID_W-1:0] fill_asid;
  logic              fill_glob;
  logic              fill_user;
  logic              fill_read;
  logic              fill_write;
  logic              fill_dirty;

  // Flush command, every entry decides on its own
  flush_e            flush_type;
  logic [ASID_W-1:0] flush_asid;
  vpn_u              flush_vpn;

  modport drv (
    output fill_en, fill_vpn, fill_ppn, fill_page, fill_asid, fill_glob,
    output fill_user, fill_read, fill_write, fill_dirty,
    output flush_type, flush_asid, flush_vpn
  );

  modport rcv (
    input fill_en, fill_vpn, fill_ppn, fill_page, fill_asid, fill_glob,
    input fill_user, fill_read, fill_write, fill_dirty,
    input flush_type, flush_asid, flush_vpn
  );

endinterface

/* hw/dtlb_pkg.sv */
package dtlb_pkg;

  // TLB geometry
  localparam int unsigned DTLB_ENTRIES = 8;
  localparam int unsigned DTLB_IDX_W   = $clog2(DTLB_ENTRIES);

  // Sv39 address fields
  localparam int unsigned VPN_W     = 27;
  localparam int unsigned VPN_LVL_W = 9;
  localparam int unsigned PPN_W     = 44;
  localparam int unsigned ASID_W    = 16;

  // Width of the load/store queue slot tag
  localparam int unsigned LSQ_TAG_W = 4;

  // Three translation levels, vpn2 is the top one
  typedef struct packed {
    logic [VPN_LVL_W-1:0] vpn2;
    logic [VPN_LVL_W-1:0] vpn1;
    logic [VPN_LVL_W-1:0] vpn0;
  } vpn_lvl_t;

  // Flat view for 4 KiB compares, level view for superpages
  typedef union packed {
    logic [VPN_W-1:0] flat;
    vpn_lvl_t         lvl;
  } vpn_u;

  typedef enum logic [1:0] {
    KIBI = 2'd0,
    MEBI = 2'd1,
    GIBI = 2'd2
  } page_e;

  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01,
    PRIV_M = 2'b11
  } priv_e;

  typedef enum logic [1:0] {
    FLUSH_NONE = 2'd0,
    FLUSH_ALL  = 2'd1,
    FLUSH_ASID = 2'd2,
    FLUSH_PAGE = 2'd3
  } flush_e;

  // VPN compare at a given page size, lower levels are don't care for superpages
  function automatic logic vpn_match(vpn_u a, vpn_u b, page_e page);
    logic m;
    case (page)
      GIBI:    m = (a.lvl.vpn2 == b.lvl.vpn2);
      MEBI:    m = (a.lvl.vpn2 == b.lvl.vpn2) && (a.lvl.vpn1 == b.lvl.vpn1);
      default: m = (a.flat == b.flat);
    endcase
    return m;
  endfunction

endpackage

/* hw/dtlb_plru.sv */
module dtlb_plru import dtlb_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic [DTLB_ENTRIES-1:0] valid_vec_i,
  input  logic [DTLB_ENTRIES-1:0] touch_vec_i,
  input  logic                    fill_en_i,
  output logic [DTLB_ENTRIES-1:0] replace_vec_o
);

  // Tree bit 1 means the next victim is on the right side
  logic [DTLB_ENTRIES-2:0] tree_q;
  logic [DTLB_ENTRIES-2:0] tree_d;
  logic [DTLB_ENTRIES-1:0] use_vec;

  always_comb begin : victim_sel
    int unsigned           node;
    logic [DTLB_IDX_W-1:0] tree_idx;
    logic [DTLB_IDX_W-1:0] free_idx;
    logic                  any_free;
    node     = 0;
    tree_idx = '0;
    free_idx = '0;
    any_free = 1'b0;
    // Walk from the root along the tree bits
    for (int l = 0; l < DTLB_IDX_W; l++) begin
      tree_idx[DTLB_IDX_W-1-l] = tree_q[node];
      node = 2 * node + 1 + int'(tree_q[node]);
    end
    // Lowest invalid entry, scanned downwards so index 0 wins
    for (int i = DTLB_ENTRIES - 1; i >= 0; i--) begin
      if (!valid_vec_i[i]) begin
        free_idx = DTLB_IDX_W'(i);
        any_free = 1'b1;
      end
    end
    replace_vec_o = '0;
    replace_vec_o[any_free ? free_idx : tree_idx] = 1'b1;
  end

  // Touch and fill never overlap
  assign use_vec = fill_en_i ? replace_vec_o : touch_vec_i;

  always_comb begin : tree_next
    int unsigned           node;
    logic [DTLB_IDX_W-1:0] use_idx;
    use_idx = '0;
    for (int i = 0; i < DTLB_ENTRIES; i++) begin
      if (use_vec[i]) begin
        use_idx = DTLB_IDX_W'(i);
      end
    end
    tree_d = tree_q;
    node   = 0;
    // Point every node on the path away from the used leaf
    for (int l = 0; l < DTLB_IDX_W; l++) begin
      tree_d[node] = ~use_idx[DTLB_IDX_W-1-l];
      node = 2 * node + 1 + int'(use_idx[DTLB_IDX_W-1-l]);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tree_q <= '0;
    end else if (|use_vec) begin
      tree_q <= tree_d;
    end
  end

  // At most one touched entry, and never together with a fill
  touch_fill_excl_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $onehot0(touch_vec_i) && !(fill_en_i && (|touch_vec_i))
  );

endmodule

/* hw/dtlb_top.sv */
module dtlb_top import dtlb_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  flush_e               flush_type_i,
  input  logic [ASID_W-1:0]    flush_asid_i,
  input  vpn_u                 flush_vpn_i,
  input  logic                 req_valid_i,
  input  vpn_u                 req_vpn_i,
  input  logic                 req_store_i,
  input  logic [LSQ_TAG_W-1:0] req_tag_i,
  output logic                 req_ready_o,
  input  logic [ASID_W-1:0]    asid_i,
  input  priv_e                priv_i,
  input  logic                 sum_i,
  input  logic                 mxr_i,
  output logic                 ans_valid_o,
  output logic [PPN_W-1:0]     ans_ppn_o,
  output logic                 ans_fault_o,
  output logic [LSQ_TAG_W-1:0] ans_tag_o,
  output logic                 ans_store_o,
  output logic                 l2_req_valid_o,
  output vpn_u                 l2_req_vpn_o,
  input  logic                 l2_req_ready_i,
  input  logic                 l2_ans_valid_i,
  input  vpn_u                 l2_ans_vpn_i,
  input  logic [PPN_W-1:0]     l2_ans_ppn_i,
  input  page_e                l2_ans_page_i,
  input  logic                 l2_ans_glob_i,
  input  logic                 l2_ans_user_i,
  input  logic                 l2_ans_read_i,
  input  logic                 l2_ans_write_i,
  input  logic                 l2_ans_dirty_i,
  input  logic                 l2_ans_fault_i,
  output logic                 wup_valid_o,
  output vpn_u                 wup_vpn_o,
  output logic [PPN_W-1:0]     wup_ppn_o,
  output logic                 wup_fault_o
);

  dtlb_lookup_if lookup_bus ();
  dtlb_maint_if  maint_bus ();

  logic                               lookup_hit;
  logic [DTLB_ENTRIES-1:0]            valid_vec;
  logic [DTLB_ENTRIES-1:0]            hit_vec;
  logic [DTLB_ENTRIES-1:0]            fault_vec;
  logic [DTLB_ENTRIES-1:0]            touch_vec;
  logic [DTLB_ENTRIES-1:0]            replace_vec;
  logic [DTLB_ENTRIES-1:0][PPN_W-1:0] ppn_arr;

  dtlb_ctrl i_dtlb_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_type_i  (flush_type_i),
    .flush_asid_i  (flush_asid_i),
    .flush_vpn_i   (flush_vpn_i),
    .req_valid_i   (req_valid_i),
    .req_vpn_i     (req_vpn_i),
    .req_store_i   (req_store_i),
    .req_ready_o   (req_ready_o),
    .asid_i        (asid_i),
    .priv_i        (priv_i),
    .sum_i         (sum_i),
    .mxr_i         (mxr_i),
    .lookup_hit_i  (lookup_hit),
    .l2_req_valid_o(l2_req_valid_o),
    .l2_req_vpn_o  (l2_req_vpn_o),
    .l2_req_ready_i(l2_req_ready_i),
    .l2_ans_valid_i(l2_ans_valid_i),
    .l2_ans_vpn_i  (l2_ans_vpn_i),
    .l2_ans_ppn_i  (l2_ans_ppn_i),
    .l2_ans_page_i (l2_ans_page_i),
    .l2_ans_glob_i (l2_ans_glob_i),
    .l2_ans_user_i (l2_ans_user_i),
    .l2_ans_read_i (l2_ans_read_i),
    .l2_ans_write_i(l2_ans_write_i),
    .l2_ans_dirty_i(l2_ans_dirty_i),
    .l2_ans_fault_i(l2_ans_fault_i),
    .wup_valid_o   (wup_valid_o),
    .wup_vpn_o     (wup_vpn_o),
    .wup_ppn_o     (wup_ppn_o),
    .wup_fault_o   (wup_fault_o),
    .lookup        (lookup_bus),
    .maint         (maint_bus)
  );

  // Entries all see the same lookup and maintenance broadcast
  for (genvar i = 0; i < DTLB_ENTRIES; i++) begin : g_entry
    dtlb_entry i_dtlb_entry (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .lookup    (lookup_bus),
      .maint     (maint_bus),
      .fill_sel_i(replace_vec[i]),
      .valid_o   (valid_vec[i]),
      .hit_o     (hit_vec[i]),
      .fault_o   (fault_vec[i]),
      .ppn_o     (ppn_arr[i])
    );
  end

  dtlb_hit_select i_dtlb_hit_select (
    .hit_vec_i   (hit_vec),
    .fault_vec_i (fault_vec),
    .ppn_arr_i   (ppn_arr),
    .req_tag_i   (req_tag_i),
    .req_store_i (req_store_i),
    .lookup_hit_o(lookup_hit),
    .touch_vec_o (touch_vec),
    .ans_valid_o (ans_valid_o),
    .ans_ppn_o   (ans_ppn_o),
    .ans_fault_o (ans_fault_o),
    .ans_tag_o   (ans_tag_o),
    .ans_store_o (ans_store_o)
  );

  // Refills also count as use for the PLRU
  dtlb_plru i_dtlb_plru (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .valid_vec_i  (valid_vec),
    .touch_vec_i  (touch_vec),
    .fill_en_i    (maint_bus.fill_en),
    .replace_vec_o(replace_vec)
  );

endmodule

/* verification/dtlb_golden.txt */
# REQ vpn store tag H|M ppn fault  /  L2ANS vpn ppn page glob user read write dirty fault
# FLUSH type asid vpn  /  CTX asid priv sum mxr  (all fields hex)
CTX 1 1 0 0
# Miss on an empty TLB, refill, then hits
REQ 0001000 0 3 M 0 0
L2ANS 0001000 abc 0 0 0 1 1 1 0
REQ 0001000 0 3 H abc 0
REQ 0001000 1 5 H abc 0
# 2 MiB and 1 GiB pages
REQ 0040423 0 6 M 0 0
L2ANS 0040400 200 1 0 0 1 1 1 0
REQ 00405ff 0 7 H 200 0
REQ 0093456 0 8 M 0 0
L2ANS 0080000 40000 2 0 0 1 1 1 0
REQ 00bffff 1 9 H 40000 0
# Permission rules
REQ 0000010 0 1 M 0 0
L2ANS 0000010 10 0 0 0 1 0 0 0
REQ 0000010 1 1 H 10 1
REQ 0000010 0 2 H 10 0
REQ 0000011 0 2 M 0 0
L2ANS 0000011 11 0 0 0 1 1 0 0
REQ 0000011 1 2 H 11 1
REQ 0000012 0 3 M 0 0
L2ANS 0000012 12 0 0 0 0 0 0 0
REQ 0000012 0 3 H 12 1
CTX 1 1 0 1
REQ 0000012 0 3 H 12 0
REQ 0000013 0 4 M 0 0
L2ANS 0000013 13 0 0 1 1 1 1 0
REQ 0000013 0 4 H 13 1
CTX 1 1 1 0
REQ 0000013 0 4 H 13 0
CTX 1 0 0 0
REQ 0000013 0 5 H 13 0
REQ 0001000 0 5 H abc 1
CTX 1 1 0 0
# Page flush on a 2 MiB entry, faulted refill is not cached
FLUSH 3 0 00405ab
REQ 0001000 0 1 H abc 0
REQ 0040400 0 1 M 0 0
L2ANS 0040400 201 1 0 0 1 1 1 1
REQ 0040400 0 2 M 0 0
L2ANS 0040400 201 1 0 0 1 1 1 0
REQ 0040456 0 2 H 201 0
# ASID flush spares the global page
REQ 0000020 0 3 M 0 0
L2ANS 0000020 20 0 1 0 1 1 1 0
FLUSH 2 1 0
REQ 0000020 0 3 H 20 0
REQ 0040400 0 4 M 0 0
L2ANS 0040400 202 1 0 0 1 1 1 0
CTX 2 1 0 0
REQ 0000020 0 5 H 20 0
REQ 0040400 0 5 M 0 0
L2ANS 0040400 203 1 0 0 1 1 1 0
REQ 0040400 0 6 H 203 0
CTX 1 1 0 0
REQ 0040400 0 6 H 202 0
# Full flush, then eight refills and a ninth
FLUSH 1 0 0
REQ 0000020 0 7 M 0 0
L2ANS 0000020 300 0 0 0 1 1 1 0
REQ 0000101 0 1 M 0 0
L2ANS 0000101 301 0 0 0 1 1 1 0
REQ 0000102 0 2 M 0 0
L2ANS 0000102 302 0 0 0 1 1 1 0
REQ 0000103 0 3 M 0 0
L2ANS 0000103 303 0 0 0 1 1 1 0
REQ 0000104 0 4 M 0 0
L2ANS 0000104 304 0 0 0 1 1 1 0
REQ 0000105 0 5 M 0 0
L2ANS 0000105 305 0 0 0 1 1 1 0
REQ 0000106 0 6 M 0 0
L2ANS 0000106 306 0 0 0 1 1 1 0
REQ 0000107 0 7 M 0 0
L2ANS 0000107 307 0 0 0 1 1 1 0
REQ 0000108 0 8 M 0 0
L2ANS 0000108 308 0 0 0 1 1 1 0
REQ 0000101 0 1 H 301 0
REQ 0000102 0 2 H 302 0
REQ 0000103 0 3 H 303 0
REQ 0000104 0 4 H 304 0
REQ 0000105 0 5 H 305 0
REQ 0000106 0 6 H 306 0
REQ 0000107 0 7 H 307 0
REQ 0000108 0 8 H 308 0
REQ 0000020 0 9 M 0 0
L2ANS 0000020 300 0 0 0 1 1 1 0

/* verification/tb_clk_gen.sv */
module tb_clk_gen #(
  parameter int PERIOD     = 8,
  parameter int RST_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_no
);

  // Free running clock
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Reset held over the first rising edges, released on a falling edge
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

/* verification/tb_dtlb.sv */
module tb_dtlb import dtlb_pkg::*; ();

  localparam int    SAMPLE_DLY      = 2;
  localparam int    CYCLES_PER_LINE = 40;
  localparam string GOLDEN_FILE     = "verification/dtlb_golden.txt";

  logic clk;
  logic rst_n;

  // DUT inputs
  flush_e               flush_type;
  logic [ASID_W-1:0]    flush_asid;
  vpn_u                 flush_vpn;
  logic                 req_valid;
  vpn_u                 req_vpn;
  logic                 req_store;
  logic [LSQ_TAG_W-1:0] req_tag;
  logic [ASID_W-1:0]    asid;
  priv_e                priv;
  logic                 sum;
  logic                 mxr;
  logic                 l2_req_ready;
  logic                 l2_ans_valid;
  vpn_u                 l2_ans_vpn;
  logic [PPN_W-1:0]     l2_ans_ppn;
  page_e                l2_ans_page;
  logic                 l2_ans_glob;
  logic                 l2_ans_user;
  logic                 l2_ans_read;
  logic                 l2_ans_write;
  logic                 l2_ans_dirty;
  logic                 l2_ans_fault;

  // DUT outputs
  logic                 req_ready;
  logic                 ans_valid;
  logic [PPN_W-1:0]     ans_ppn;
  logic                 ans_fault;
  logic [LSQ_TAG_W-1:0] ans_tag;
  logic                 ans_store;
  logic                 l2_req_valid;
  vpn_u                 l2_req_vpn;
  logic                 wup_valid;
  vpn_u                 wup_vpn;
  logic [PPN_W-1:0]     wup_ppn;
  logic                 wup_fault;

  int          err_cnt    = 0;
  int          op_cnt     = 0;
  int unsigned cycle_cnt  = 0;
  int unsigned max_cycles = 0;
  integer      seed       = 32'h33d5_23eb;

  tb_clk_gen #(.PERIOD(8), .RST_CYCLES(4)) i_clk_gen (
    .clk_o (clk),
    .rst_no(rst_n)
  );

  dtlb_top i_dtlb_top (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .flush_type_i  (flush_type),
    .flush_asid_i  (flush_asid),
    .flush_vpn_i   (flush_vpn),
    .req_valid_i   (req_valid),
    .req_vpn_i     (req_vpn),
    .req_store_i   (req_store),
    .req_tag_i     (req_tag),
    .req_ready_o   (req_ready),
    .asid_i        (asid),
    .priv_i        (priv),
    .sum_i         (sum),
    .mxr_i         (mxr),
    .ans_valid_o   (ans_valid),
    .ans_ppn_o     (ans_ppn),
    .ans_fault_o   (ans_fault),
    .ans_tag_o     (ans_tag),
    .ans_store_o   (ans_store),
    .l2_req_valid_o(l2_req_valid),
    .l2_req_vpn_o  (l2_req_vpn),
    .l2_req_ready_i(l2_req_ready),
    .l2_ans_valid_i(l2_ans_valid),
    .l2_ans_vpn_i  (l2_ans_vpn),
    .l2_ans_ppn_i  (l2_ans_ppn),
    .l2_ans_page_i (l2_ans_page),
    .l2_ans_glob_i (l2_ans_glob),
    .l2_ans_user_i (l2_ans_user),
    .l2_ans_read_i (l2_ans_read),
    .l2_ans_write_i(l2_ans_write),
    .l2_ans_dirty_i(l2_ans_dirty),
    .l2_ans_fault_i(l2_ans_fault),
    .wup_valid_o   (wup_valid),
    .wup_vpn_o     (wup_vpn),
    .wup_ppn_o     (wup_ppn),
    .wup_fault_o   (wup_fault)
  );

  // Run limit scales with the golden file length
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (max_cycles != 0 && cycle_cnt > max_cycles) begin
      $display("Timeout, run stopped after %0d cycles", cycle_cnt);
      $display("Operations: %0d, errors: %0d", op_cnt, err_cnt + 1);
      $display("Something failed");
      $finish;
    end
  end

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("FAILED %s: got %h, expected %h", name, got, exp);
    err_cnt++;
  endtask

  // Called on a falling edge, returns on the first one with ready high
  task automatic wait_req_ready();
    while (req_ready !== 1'b1) begin
      @(negedge clk);
    end
  endtask

  // L2 side of a miss, random back-pressure then one accept cycle
  task automatic serve_l2_req(input logic [VPN_W-1:0] vpn);
    int unsigned hold;
    if (l2_req_valid !== 1'b1) begin
      $display("No L2 request was raised after a miss on vpn %h", vpn);
      err_cnt++;
    end else begin
      if (l2_req_vpn.flat !== vpn)
        report_mismatch("l2_req_vpn_o", l2_req_vpn.flat, vpn);
      hold = $unsigned($random(seed)) % 4;
      repeat (hold) begin
        @(negedge clk);
        // Request must hold while ready is low
        if (l2_req_valid !== 1'b1)
          report_mismatch("l2_req_valid_o", l2_req_valid, 1'b1);
        if (l2_req_vpn.flat !== vpn)
          report_mismatch("l2_req_vpn_o", l2_req_vpn.flat, vpn);
        if (req_ready !== 1'b0)
          report_mismatch("req_ready_o", req_ready, 1'b0);
      end
      l2_req_ready = 1'b1;
      @(negedge clk);
      l2_req_ready = 1'b0;
      // Handed over, miss now waits for the answer
      if (l2_req_valid !== 1'b0)
        report_mismatch("l2_req_valid_o", l2_req_valid, 1'b0);
      if (req_ready !== 1'b0)
        report_mismatch("req_ready_o", req_ready, 1'b0);
    end
  endtask

  task automatic run_req(input logic [VPN_W-1:0] vpn, input logic store,
                         input logic [LSQ_TAG_W-1:0] tag, input logic exp_hit,
                         input logic [PPN_W-1:0] exp_ppn, input logic exp_fault);
    wait_req_ready();
    req_valid    = 1'b1;
    req_vpn.flat = vpn;
    req_store    = store;
    req_tag      = tag;
    // Answer is combinational in the accept cycle
    #(SAMPLE_DLY);
    if (ans_valid !== exp_hit)
      report_mismatch("ans_valid_o", ans_valid, exp_hit);
    if (exp_hit) begin
      if (ans_ppn !== exp_ppn)
        report_mismatch("ans_ppn_o", ans_ppn, exp_ppn);
      if (ans_fault !== exp_fault)
        report_mismatch("ans_fault_o", ans_fault, exp_fault);
      if (ans_tag !== tag)
        report_mismatch("ans_tag_o", ans_tag, tag);
      if (ans_store !== store)
        report_mismatch("ans_store_o", ans_store, store);
    end
    @(negedge clk);
    req_valid = 1'b0;
    if (!exp_hit) begin
      serve_l2_req(vpn);
    end
  endtask

  task automatic run_l2_ans(input logic [VPN_W-1:0] vpn, input logic [PPN_W-1:0] ppn,
                            input logic [1:0] page, input logic glob, input logic user,
                            input logic rd, input logic wr, input logic dirty,
                            input logic fault);
    l2_ans_valid    = 1'b1;
    l2_ans_vpn.flat = vpn;
    l2_ans_ppn      = ppn;
    l2_ans_page     = page_e'(page);
    l2_ans_glob     = glob;
    l2_ans_user     = user;
    l2_ans_read     = rd;
    l2_ans_write    = wr;
    l2_ans_dirty    = dirty;
    l2_ans_fault    = fault;
    #(SAMPLE_DLY);
    // Wake-up forwards the answer in the same cycle
    if (wup_valid !== 1'b1)
      report_mismatch("wup_valid_o", wup_valid, 1'b1);
    if (wup_vpn.flat !== vpn)
      report_mismatch("wup_vpn_o", wup_vpn.flat, vpn);
    if (wup_ppn !== ppn)
      report_mismatch("wup_ppn_o", wup_ppn, ppn);
    if (wup_fault !== fault)
      report_mismatch("wup_fault_o", wup_fault, fault);
    @(negedge clk);
    l2_ans_valid = 1'b0;
    #(SAMPLE_DLY);
    // Miss is gone, new requests are taken again
    if (req_ready !== 1'b1)
      report_mismatch("req_ready_o", req_ready, 1'b1);
    @(negedge clk);
  endtask

  task automatic run_flush(input logic [1:0] kind, input logic [ASID_W-1:0] fasid,
                           input logic [VPN_W-1:0] fvpn);
    flush_type     = flush_e'(kind);
    flush_asid     = fasid;
    flush_vpn.flat = fvpn;
    #(SAMPLE_DLY);
    if (req_ready !== 1'b0)
      report_mismatch("req_ready_o", req_ready, 1'b0);
    @(negedge clk);
    flush_type = FLUSH_NONE;
  endtask

  initial begin : main
    int          fd;
    int          rc;
    int          line_cnt;
    string       line;
    string       op;
    string       res;
    logic [63:0] fld0;
    logic [63:0] fld1;
    logic [63:0] fld2;
    logic [63:0] fld3;
    logic [63:0] fld4;
    logic [63:0] fld5;
    logic [63:0] fld6;
    logic [63:0] fld7;
    logic [63:0] fld8;
    // All inputs idle from time zero
    flush_type   = FLUSH_NONE;
    flush_asid   = '0;
    flush_vpn    = '0;
    req_valid    = 1'b0;
    req_vpn      = '0;
    req_store    = 1'b0;
    req_tag      = '0;
    asid         = '0;
    priv         = PRIV_S;
    sum          = 1'b0;
    mxr          = 1'b0;
    l2_req_ready = 1'b0;
    l2_ans_valid = 1'b0;
    l2_ans_vpn   = '0;
    l2_ans_ppn   = '0;
    l2_ans_page  = KIBI;
    l2_ans_glob  = 1'b0;
    l2_ans_user  = 1'b0;
    l2_ans_read  = 1'b0;
    l2_ans_write = 1'b0;
    l2_ans_dirty = 1'b0;
    l2_ans_fault = 1'b0;
    fd = $fopen(GOLDEN_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the golden file %s", GOLDEN_FILE);
      err_cnt++;
    end else begin
      // First pass only sizes the run limit
      line_cnt = 0;
      while ($fgets(line, fd) != 0) begin
        line_cnt++;
      end
      $fclose(fd);
      max_cycles = CYCLES_PER_LINE * line_cnt;
      fd = $fopen(GOLDEN_FILE, "r");
      @(posedge rst_n);
      @(negedge clk);
      // Idle state straight after reset
      if (req_ready !== 1'b1)
        report_mismatch("req_ready_o", req_ready, 1'b1);
      if (ans_valid !== 1'b0)
        report_mismatch("ans_valid_o", ans_valid, 1'b0);
      if (l2_req_valid !== 1'b0)
        report_mismatch("l2_req_valid_o", l2_req_valid, 1'b0);
      if (wup_valid !== 1'b0)
        report_mismatch("wup_valid_o", wup_valid, 1'b0);
      while ($fscanf(fd, "%s", op) == 1) begin
        if (op[0] == "#") begin
          rc = $fgets(line, fd);
        end else if (op == "CTX") begin
          rc = $fscanf(fd, "%h %h %h %h", fld0, fld1, fld2, fld3);
          asid = fld0[ASID_W-1:0];
          priv = priv_e'(fld1[1:0]);
          sum  = fld2[0];
          mxr  = fld3[0];
          op_cnt++;
        end else if (op == "FLUSH") begin
          rc = $fscanf(fd, "%h %h %h", fld0, fld1, fld2);
          run_flush(fld0[1:0], fld1[ASID_W-1:0], fld2[VPN_W-1:0]);
          op_cnt++;
        end else if (op == "REQ") begin
          rc = $fscanf(fd, "%h %h %h %s %h %h", fld0, fld1, fld2, res, fld3, fld4);
          run_req(fld0[VPN_W-1:0], fld1[0], fld2[LSQ_TAG_W-1:0], res == "H",
                  fld3[PPN_W-1:0], fld4[0]);
          op_cnt++;
        end else if (op == "L2ANS") begin
          rc = $fscanf(fd, "%h %h %h %h %h %h %h %h %h",
                       fld0, fld1, fld2, fld3, fld4, fld5, fld6, fld7, fld8);
          run_l2_ans(fld0[VPN_W-1:0], fld1[PPN_W-1:0], fld2[1:0], fld3[0], fld4[0],
                     fld5[0], fld6[0], fld7[0], fld8[0]);
          op_cnt++;
        end else begin
          $display("Unknown operation %s in the golden file", op);
          err_cnt++;
          rc = $fgets(line, fd);
        end
      end
      $fclose(fd);
    end
    $display("Operations: %0d, errors: %0d", op_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
hw/dtlb_pkg.sv
hw/dtlb_lookup_if.sv
hw/dtlb_maint_if.sv
hw/dtlb_ctrl.sv
hw/dtlb_entry.sv
hw/dtlb_hit_select.sv
hw/dtlb_plru.sv
hw/dtlb_top.sv
verification/tb_clk_gen.sv
verification/tb_dtlb.sv
